// File: src/vector_divider_config.svh
// Vector divider configuration
// Widths and FIFO depth shared by the packages and RTL

`ifndef VECTOR_DIVIDER_CONFIG_SVH
`define VECTOR_DIVIDER_CONFIG_SVH

// Operand, modulus and result width
`define VD_DATA_WIDTH 16

// Vector length and element index width
`define VD_LEN_WIDTH 8

// Entries per FIFO, also initial credits of each sender
`define VD_FIFO_DEPTH 4

// Credit counters must hold VD_FIFO_DEPTH
`define VD_CREDIT_WIDTH 3

`endif

// File: src/div_data_pkg.sv
// Divider data package
// Payload structs carried on the operand and result links

`include "vector_divider_config.svh"

package div_data_pkg;

  //////////////////////////////////////////////////
  // Operand link payload
  //////////////////////////////////////////////////

  // One element of the vector, result is b / a
  typedef struct packed {
    logic [`VD_DATA_WIDTH-1:0] b;
    logic [`VD_DATA_WIDTH-1:0] a;
  } operand_pair_t;

  //////////////////////////////////////////////////
  // Result link payload
  //////////////////////////////////////////////////

  // Reduced quotient plus status bits
  typedef struct packed {
    logic [`VD_DATA_WIDTH-1:0] value;
    // Divisor was zero, value forced to zero
    logic                      div_by_zero;
    // Final element of the vector
    logic                      last;
  } result_t;

endpackage

// File: src/div_ctrl_pkg.sv
// Divider control package
// Vector command format and sequencer FSM states

`include "vector_divider_config.svh"

package div_ctrl_pkg;

  //////////////////////////////////////////////////
  // Command
  //////////////////////////////////////////////////

  // Modulus of zero disables the reduction
  // Length of zero runs a single element
  typedef struct packed {
    logic [`VD_DATA_WIDTH-1:0] modulus;
    logic [`VD_LEN_WIDTH-1:0]  length;
  } vector_cmd_t;

  //////////////////////////////////////////////////
  // Sequencer FSM
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    DIVIDE,
    WRITE
  } seq_state_t;

endpackage

// File: src/credit_fifo.sv
// Credit-based receiving FIFO
// Circular buffer with any payload type, one credit returned per pop
// Sender is trusted never to overrun, so no full flag

`include "vector_divider_config.svh"

module credit_fifo #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     RST,
  // Write side, guarded by sender credits
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     credit,
  // Head of queue
  output logic     out_valid,
  output payload_t out_data,
  input  logic     pop
);

  localparam int DEPTH = `VD_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  payload_t                    mem [DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [`VD_CREDIT_WIDTH-1:0] count;
  logic                        do_pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // Head and credit return
  //////////////////////////////////////////////////

  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  // Pop on empty is ignored
  assign do_pop    = pop && out_valid;
  // Slot freed this cycle
  assign credit    = do_pop;

  //////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous push and pop keeps the count
      case ({in_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage, visible at the head one cycle after the write
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

// File: src/result_egress.sv
// Result egress
// Moves results from the output FIFO head to the outside port
// under credits returned by the external receiver

`include "vector_divider_config.svh"

module result_egress (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  head_valid,
  input  div_data_pkg::result_t head_data,
  output logic                  head_pop,
  output logic                  res_valid,
  output div_data_pkg::result_t res_data,
  input  logic                  res_credit
);

  logic [`VD_CREDIT_WIDTH-1:0] credits;
  logic                        send;

  // Take the head only while the receiver has room
  assign send     = head_valid && (credits != '0);
  assign head_pop = send;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credits   <= `VD_CREDIT_WIDTH'(`VD_FIFO_DEPTH);
      res_valid <= 1'b0;
    end else begin
      res_valid <= send;
      // Send and return together cancel out
      case ({send, res_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Output payload register
  always_ff @(posedge CLK) begin
    if (send) begin
      res_data <= head_data;
    end
  end

endmodule

// File: src/scalar_divider.sv
// Bit-serial scalar divider
// Restoring division b / a, then a second restoring pass
// that reduces the quotient modulo the modulus

`include "vector_divider_config.svh"

module scalar_divider (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  // Held stable from start until ready
  input  logic [`VD_DATA_WIDTH-1:0] dividend,
  input  logic [`VD_DATA_WIDTH-1:0] divisor,
  input  logic [`VD_DATA_WIDTH-1:0] modulus,
  output logic                      ready,
  output logic [`VD_DATA_WIDTH-1:0] quotient,
  output logic                      div_by_zero
);

  localparam int W     = `VD_DATA_WIDTH;
  localparam int CNT_W = $clog2(W);

  // Control
  logic             busy;
  // 0 divides by divisor, 1 reduces by modulus
  logic             phase;
  logic [CNT_W-1:0] step;
  logic             last_step;

  // Datapath registers
  logic [W-1:0]     rem;
  logic [W-1:0]     shreg;
  logic [W-1:0]     q_hold;

  // One restoring step
  logic [W-1:0]     den;
  logic [W:0]       rem_shift;
  logic [W:0]       diff;
  logic             fit;
  logic [W-1:0]     rem_next;
  logic [W-1:0]     sh_next;

  //////////////////////////////////////////////////
  // Restoring step
  //////////////////////////////////////////////////

  always_comb begin
    den       = phase ? modulus : divisor;
    // Bring down the next numerator bit
    rem_shift = {rem, shreg[W-1]};
    diff      = rem_shift - {1'b0, den};
    // No borrow, the denominator fits
    fit       = ~diff[W];
    rem_next  = fit ? diff[W-1:0] : rem_shift[W-1:0];
    sh_next   = {shreg[W-2:0], fit};
    last_step = (step == CNT_W'(W - 1));
  end

  //////////////////////////////////////////////////
  // Sequencing, W steps per phase
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      phase <= 1'b0;
      step  <= '0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (!busy) begin
        // Start ignored while a division runs
        if (start) begin
          busy  <= 1'b1;
          phase <= 1'b0;
          step  <= '0;
        end
      end else begin
        step <= last_step ? '0 : step + 1'b1;
        if (last_step) begin
          if (!phase) begin
            phase <= 1'b1;
          end else begin
            busy  <= 1'b0;
            ready <= 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!busy && start) begin
      rem   <= '0;
      shreg <= dividend;
    end else if (busy) begin
      if (last_step && !phase) begin
        // Quotient becomes the numerator of the second pass
        rem    <= '0;
        shreg  <= sh_next;
        q_hold <= sh_next;
      end else begin
        rem   <= rem_next;
        shreg <= sh_next;
      end
      // Final step, remainder of the second pass is the result
      if (last_step && phase) begin
        div_by_zero <= (divisor == '0);
        if (divisor == '0) begin
          quotient <= '0;
        end else if (modulus == '0) begin
          quotient <= q_hold;
        end else begin
          quotient <= rem_next;
        end
      end
    end
  end

endmodule

// File: src/vector_sequencer.sv
// Vector sequencer
// Walks one vector element by element, feeds the scalar divider
// and writes each result to the output FIFO under credits

`include "vector_divider_config.svh"

module vector_sequencer (
  input  logic                          CLK,
  input  logic                          RST,
  // Command
  input  logic                          start,
  input  div_ctrl_pkg::vector_cmd_t     cmd,
  output logic                          ready,
  // Operand FIFO head
  input  logic                          op_valid,
  input  div_data_pkg::operand_pair_t   op_data,
  output logic                          op_pop,
  // Scalar divider
  output logic                          div_start,
  output logic [`VD_DATA_WIDTH-1:0]     div_dividend,
  output logic [`VD_DATA_WIDTH-1:0]     div_divisor,
  output logic [`VD_DATA_WIDTH-1:0]     div_modulus,
  input  logic                          div_ready,
  input  logic [`VD_DATA_WIDTH-1:0]     div_quotient,
  input  logic                          div_zero,
  // Output FIFO write, credit based
  output logic                          res_valid,
  output div_data_pkg::result_t         res_data,
  input  logic                          res_credit
);

  div_ctrl_pkg::seq_state_t    state;
  div_ctrl_pkg::vector_cmd_t   cmd_q;
  logic [`VD_LEN_WIDTH-1:0]    index;
  logic [`VD_LEN_WIDTH-1:0]    last_idx;
  logic                        is_last;
  logic [`VD_CREDIT_WIDTH-1:0] credits;
  logic                        can_fetch;
  logic                        issue;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  // Zero length runs as one element
  assign last_idx    = (cmd_q.length == '0) ? '0 : cmd_q.length - 1'b1;
  assign is_last     = (index == last_idx);
  // Stall here without an output credit, back-pressure to the input
  assign can_fetch   = (state == div_ctrl_pkg::FETCH) && op_valid && (credits != '0);
  assign op_pop      = can_fetch;
  assign issue       = (state == div_ctrl_pkg::WRITE);
  assign div_modulus = cmd_q.modulus;

  //////////////////////////////////////////////////
  // FSM and credits
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= div_ctrl_pkg::IDLE;
      index     <= '0;
      credits   <= `VD_CREDIT_WIDTH'(`VD_FIFO_DEPTH);
      div_start <= 1'b0;
      res_valid <= 1'b0;
      ready     <= 1'b0;
    end else begin
      div_start <= 1'b0;
      res_valid <= 1'b0;
      // One cycle after the last result enters the output FIFO
      ready     <= res_valid && res_data.last;

      case ({issue, res_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase

      case (state)
        div_ctrl_pkg::IDLE: begin
          if (start) begin
            index <= '0;
            state <= div_ctrl_pkg::FETCH;
          end
        end
        div_ctrl_pkg::FETCH: begin
          if (can_fetch) begin
            div_start <= 1'b1;
            state     <= div_ctrl_pkg::DIVIDE;
          end
        end
        div_ctrl_pkg::DIVIDE: begin
          // Single element in the divider at a time
          if (div_ready) begin
            state <= div_ctrl_pkg::WRITE;
          end
        end
        div_ctrl_pkg::WRITE: begin
          res_valid <= 1'b1;
          if (is_last) begin
            state <= div_ctrl_pkg::IDLE;
          end else begin
            index <= index + 1'b1;
            state <= div_ctrl_pkg::FETCH;
          end
        end
        default: begin
          state <= div_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Payload registers
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if ((state == div_ctrl_pkg::IDLE) && start) begin
      cmd_q <= cmd;
    end
    // Operands stay put until the divider finishes
    if (can_fetch) begin
      div_dividend <= op_data.b;
      div_divisor  <= op_data.a;
    end
    if ((state == div_ctrl_pkg::DIVIDE) && div_ready) begin
      res_data.value       <= div_quotient;
      res_data.div_by_zero <= div_zero;
    end
    if (issue) begin
      res_data.last <= is_last;
    end
  end

endmodule

// File: src/vector_divider.sv
// Vector modular divider, top level
// Input FIFO, sequencer, scalar divider, output FIFO and egress

`include "vector_divider_config.svh"

module vector_divider (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  div_ctrl_pkg::vector_cmd_t   cmd,
  output logic                        ready,
  input  logic                        in_valid,
  input  div_data_pkg::operand_pair_t in_data,
  output logic                        in_credit,
  output logic                        res_valid,
  output div_data_pkg::result_t       res_data,
  input  logic                        res_credit
);

  // Operand FIFO head
  logic                        op_valid;
  div_data_pkg::operand_pair_t op_data;
  logic                        op_pop;

  // Sequencer to divider
  logic                        div_start;
  logic                        div_ready;
  logic [`VD_DATA_WIDTH-1:0]   div_dividend;
  logic [`VD_DATA_WIDTH-1:0]   div_divisor;
  logic [`VD_DATA_WIDTH-1:0]   div_modulus;
  logic [`VD_DATA_WIDTH-1:0]   div_quotient;
  logic                        div_zero;

  // Sequencer to output FIFO
  logic                        wr_valid;
  div_data_pkg::result_t       wr_data;
  logic                        wr_credit;

  // Output FIFO head
  logic                        head_valid;
  div_data_pkg::result_t       head_data;
  logic                        head_pop;

  //////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////

  credit_fifo #(
    .payload_t (div_data_pkg::operand_pair_t)
  ) u_in_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .credit    (in_credit),
    .out_valid (op_valid),
    .out_data  (op_data),
    .pop       (op_pop)
  );

  //////////////////////////////////////////////////
  // Processing
  //////////////////////////////////////////////////

  vector_sequencer u_seq (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .cmd          (cmd),
    .ready        (ready),
    .op_valid     (op_valid),
    .op_data      (op_data),
    .op_pop       (op_pop),
    .div_start    (div_start),
    .div_dividend (div_dividend),
    .div_divisor  (div_divisor),
    .div_modulus  (div_modulus),
    .div_ready    (div_ready),
    .div_quotient (div_quotient),
    .div_zero     (div_zero),
    .res_valid    (wr_valid),
    .res_data     (wr_data),
    .res_credit   (wr_credit)
  );

  scalar_divider u_div (
    .CLK         (CLK),
    .RST         (RST),
    .start       (div_start),
    .dividend    (div_dividend),
    .divisor     (div_divisor),
    .modulus     (div_modulus),
    .ready       (div_ready),
    .quotient    (div_quotient),
    .div_by_zero (div_zero)
  );

  //////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////

  credit_fifo #(
    .payload_t (div_data_pkg::result_t)
  ) u_out_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (wr_valid),
    .in_data   (wr_data),
    .credit    (wr_credit),
    .out_valid (head_valid),
    .out_data  (head_data),
    .pop       (head_pop)
  );

  result_egress u_egress (
    .CLK        (CLK),
    .RST        (RST),
    .head_valid (head_valid),
    .head_data  (head_data),
    .head_pop   (head_pop),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .res_credit (res_credit)
  );

endmodule

// File: dv/clock_gen.sv
// Testbench clock and reset
// Free running clock, reset held high for a fixed number of cycles

module clock_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Release away from the active edge
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

// File: dv/vector_divider_tb.sv
// Vector divider testbench
// Random and directed vectors checked against a reference model,
// with credit back-pressure on both links

`include "vector_divider_config.svh"

module vector_divider_tb;

  localparam int W           = `VD_DATA_WIDTH;
  localparam int DEPTH       = `VD_FIFO_DEPTH;
  localparam int HOLD_CYCLES = 300;
  // Upper bound on elements over all tests
  localparam int MAX_ELEMS   = 10 * 8 + 6 + 12 + 12;
  localparam int LIMIT       = 16 + MAX_ELEMS * (2 * W + 10) + HOLD_CYCLES + 500;

  logic                        CLK;
  logic                        RST;
  logic                        start;
  div_ctrl_pkg::vector_cmd_t   cmd;
  logic                        ready;
  logic                        in_valid;
  div_data_pkg::operand_pair_t in_data;
  logic                        in_credit;
  logic                        res_valid;
  div_data_pkg::result_t       res_data;
  logic                        res_credit;

  // Pending operands and expected results, in order
  div_data_pkg::operand_pair_t op_q[$];
  div_data_pkg::result_t       exp_q[$];
  string                       test_name = "reset";
  int                          errors = 0;
  int                          results_seen = 0;
  int                          cmd_count = 0;
  int                          ready_count = 0;
  int                          lasts_written = 0;
  // Input link credits held by the driver
  int                          in_credits = DEPTH;
  int                          ops_sent = 0;
  int                          credits_back = 0;
  // Results received but not yet credited back
  int                          owed = 0;
  logic                        hold_credits = 1'b0;

  clock_gen u_clk (
    .CLK (CLK),
    .RST (RST)
  );

  vector_divider DUT (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .cmd        (cmd),
    .ready      (ready),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .res_credit (res_credit)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Floor quotient, then remainder by a nonzero modulus
  function automatic div_data_pkg::result_t expected_result(
    input logic [W-1:0] b,
    input logic [W-1:0] a,
    input logic [W-1:0] m,
    input logic         last
  );
    div_data_pkg::result_t r;
    r.last        = last;
    r.div_by_zero = (a == '0);
    if (a == '0) begin
      r.value = '0;
    end else begin
      r.value = b / a;
      if (m != '0) begin
        r.value = r.value % m;
      end
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Operand driver, credit based
  //////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (in_credit) begin
        in_credits++;
        credits_back++;
      end
      // Input FIFO has only DEPTH slots to grant
      if (in_credits > DEPTH) begin
        errors++;
        $display("ERROR: in_credit granted room for more than %0d operands", DEPTH);
      end
      in_valid = 1'b0;
      if (op_q.size() != 0 && in_credits != 0) begin
        in_data  = op_q.pop_front();
        in_valid = 1'b1;
        in_credits--;
        ops_sent++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Result compare and credit return
  //////////////////////////////////////////////////

  always @(negedge CLK) begin
    div_data_pkg::result_t exp;
    if (!RST) begin
      if (res_valid) begin
        results_seen++;
        owed++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR: result %h arrived with nothing expected", res_data);
        end else begin
          exp = exp_q.pop_front();
          if (res_data !== exp) begin
            errors++;
            $display("FAIL %s: result %0d expected %h/%b/%b actual %h/%b/%b",
                     test_name, results_seen, exp.value, exp.div_by_zero, exp.last,
                     res_data.value, res_data.div_by_zero, res_data.last);
          end
        end
        // Receiver has only DEPTH slots
        if (owed > DEPTH) begin
          errors++;
          $display("ERROR: egress sent a result without holding a credit");
        end
      end
      res_credit = 1'b0;
      if (!hold_credits && owed != 0) begin
        res_credit = 1'b1;
        owed--;
      end
      if (ready) begin
        ready_count++;
        if (lasts_written != ready_count) begin
          errors++;
          $display("ERROR: ready pulsed before the last result was written");
        end
        if (ready_count > cmd_count) begin
          errors++;
          $display("ERROR: ready pulsed with no command outstanding");
        end
      end
      // Peek at the output FIFO write to time ready
      if (DUT.wr_valid && DUT.wr_data.last) begin
        lasts_written++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    repeat (LIMIT) @(posedge CLK);
    $display("ERROR: timeout after %0d cycles in test %s", LIMIT, test_name);
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic queue_element(input logic [W-1:0] b, input logic [W-1:0] a,
                               input logic [W-1:0] m, input logic last);
    div_data_pkg::operand_pair_t op;
    op.b = b;
    op.a = a;
    op_q.push_back(op);
    exp_q.push_back(expected_result(b, a, m, last));
  endtask

  task automatic issue_command(input logic [W-1:0] m, input int len);
    @(negedge CLK);
    cmd.modulus = m;
    cmd.length  = len[`VD_LEN_WIDTH-1:0];
    start       = 1'b1;
    cmd_count++;
    @(negedge CLK);
    start = 1'b0;
  endtask

  // Until ready and every result has been compared
  task automatic finish_vector();
    while (ready_count < cmd_count) @(negedge CLK);
    while (exp_q.size() != 0) @(negedge CLK);
  endtask

  task automatic random_vector(input logic [W-1:0] m, input int len, input int amax);
    for (int i = 0; i < len; i++) begin
      queue_element(W'($urandom), W'($urandom % amax + 1), m, i == len - 1);
    end
    issue_command(m, len);
    finish_vector();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    logic [W-1:0] m;
    void'($urandom(32'hb53fb760));
    start      = 1'b0;
    cmd        = '0;
    in_valid   = 1'b0;
    in_data    = '0;
    res_credit = 1'b0;
    @(negedge RST);
    repeat (2) @(negedge CLK);

    // Random vectors, some with zero modulus
    test_name = "basic";
    for (int t = 0; t < 10; t++) begin
      m = ($urandom % 4 == 0) ? '0 : W'($urandom % 500);
      random_vector(m, 1 + $urandom % 8, 300);
    end

    // Zero divisors between normal elements
    test_name = "zero_divisor";
    m = W'($urandom % 100 + 1);
    for (int i = 0; i < 6; i++) begin
      queue_element(W'($urandom), (i % 2 == 0) ? '0 : W'($urandom % 50 + 1), m, i == 5);
    end
    issue_command(m, 6);
    finish_vector();

    test_name = "modulus_zero";
    random_vector('0, 4, 50);
    test_name = "modulus_one";
    random_vector(W'(1), 4, 50);
    test_name = "small_dividend";
    m = W'($urandom % 100 + 1);
    for (int i = 0; i < 4; i++) begin
      queue_element(W'($urandom % 1000), W'(1000 + $urandom % 1000), m, i == 3);
    end
    issue_command(m, 4);
    finish_vector();

    // Withhold result credits, vector stalls in the DUT
    test_name = "backpressure";
    repeat (8) @(negedge CLK);
    hold_credits = 1'b1;
    begin
      int seen_before;
      int ready_before;
      seen_before  = results_seen;
      ready_before = ready_count;
      m = W'($urandom % 1000);
      for (int i = 0; i < 12; i++) begin
        queue_element(W'($urandom), W'($urandom % 200 + 1), m, i == 11);
      end
      issue_command(m, 12);
      repeat (HOLD_CYCLES) @(negedge CLK);
      if (results_seen - seen_before != DEPTH) begin
        errors++;
        $display("FAIL %s: results without credits expected %0d actual %0d",
                 test_name, DEPTH, results_seen - seen_before);
      end
      if (ready_count != ready_before) begin
        errors++;
        $display("ERROR: ready pulsed while the vector was stalled");
      end
    end
    hold_credits = 1'b0;
    finish_vector();

    // Link accounting
    test_name = "completion";
    repeat (10) @(negedge CLK);
    if (credits_back != ops_sent) begin
      errors++;
      $display("FAIL %s: in_credit pulses expected %0d actual %0d",
               test_name, ops_sent, credits_back);
    end
    if (ready_count != cmd_count) begin
      errors++;
      $display("FAIL %s: ready pulses expected %0d actual %0d",
               test_name, cmd_count, ready_count);
    end

    $display("Summary: %0d errors, %0d results, %0d commands, %0d ready pulses",
             errors, results_seen, cmd_count, ready_count);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: vector_divider.f
+incdir+src
src/div_data_pkg.sv
src/div_ctrl_pkg.sv
src/credit_fifo.sv
src/result_egress.sv
src/scalar_divider.sv
src/vector_sequencer.sv
src/vector_divider.sv
dv/clock_gen.sv
dv/vector_divider_tb.sv
